// ==== common/alu_op_pkg.sv ====
// ALU operation definitions

package alu_op_pkg;

    ////////////////////
    // opcode encoding
    ////////////////////

    // 00xx arithmetic, 01xx logic, 1xxx special
    typedef enum logic [3:0] {
        op_add        = 4'd0,
        op_sub        = 4'd1,
        op_mul        = 4'd2,
        op_div        = 4'd3,
        op_not        = 4'd4,
        op_and        = 4'd5,
        op_or         = 4'd6,
        op_xor        = 4'd7,
        op_write_high = 4'd8,   // {b[15:0], a[15:0]}
        op_write_low  = 4'd9,   // {a[31:16], b[15:0]}
        op_itof       = 4'd10,  // passes a through
        op_ftoi       = 4'd11   // passes a through
    } alu_op_e;

    ////////////////////
    // execution classes
    ////////////////////

    typedef enum logic [1:0] {
        cls_single = 2'd0,      // done in the dispatch stage
        cls_mul    = 2'd1,      // pipelined multiplier
        cls_div    = 2'd2       // iterative divider
    } op_class_e;

    // one request on the input stream, 68 bits
    typedef struct packed {
        alu_op_e            op;
        logic signed [31:0] a;
        logic signed [31:0] b;
    } alu_req_t;

endpackage

// ==== common/alu_result_pkg.sv ====
// ALU result definitions

package alu_result_pkg;

    // result flags
    typedef struct packed {
        logic nonzero;          // full-precision value is not zero
        logic negative;         // sign of the full-precision value
    } alu_flags_t;

    // one response on the output stream, 34 bits
    typedef struct packed {
        logic [31:0] data;
        alu_flags_t  flags;
    } alu_resp_t;

    // Result as handed from an execution unit to the merge stage.
    // The value is sign-extended from its natural precision, so data is
    // the low word and both flags can be taken from the whole value.
    typedef struct packed {
        logic signed [63:0] wide;
    } unit_result_t;

endpackage

// ==== src/stream_skid.sv ====
`timescale 1ns/10ps
// Two-entry stream buffer

module stream_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   mem [2];        // entry storage
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [1:0] count_next;
    logic       push;
    logic       pop;
    logic       ready_q;        // registered, depends on occupancy only

    assign push       = in_valid && ready_q;
    assign pop        = out_valid && out_ready;
    assign count_next = count + 2'(push) - 2'(pop);

    assign in_ready  = ready_q;
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];     // head entry

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= 2'd0;
            ready_q <= 1'b0;    // rises in the first cycle after reset
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count   <= count_next;
            ready_q <= (count_next != 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// ==== src/alu_dispatch.sv ====
`timescale 1ns/10ps
// Request decode and issue

module alu_dispatch #(
    parameter int MUL_STAGES = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  alu_op_pkg::alu_req_t        req,
    output logic                        single_valid,
    input  logic                        single_ready,
    output alu_result_pkg::unit_result_t single_result,
    output logic                        mul_start,
    input  logic                        mul_enable,
    output logic signed [31:0]          mul_a,
    output logic signed [31:0]          mul_b,
    output logic                        div_valid,
    input  logic                        div_ready,
    output logic signed [31:0]          div_a,
    output logic signed [31:0]          div_b,
    input  logic                        mul_retire,
    input  logic                        div_retire
);

    localparam int CW = $clog2(MUL_STAGES + 1);

    alu_op_pkg::op_class_e cls;
    logic [CW-1:0]         mul_cnt;         // multiplies in flight
    logic                  div_busy;        // divide in flight
    logic                  mul_idle;
    logic                  mul_room;
    logic                  single_load;
    logic signed [31:0]    op_a;
    logic signed [31:0]    op_b;
    logic signed [31:0]    word;
    logic signed [63:0]    wide;

    assign op_a = req.a;
    assign op_b = req.b;

    always_comb begin
        case (req.op)
            alu_op_pkg::op_mul: cls = alu_op_pkg::cls_mul;
            alu_op_pkg::op_div: cls = alu_op_pkg::cls_div;
            default:            cls = alu_op_pkg::cls_single;
        endcase
    end

    ////////////////////
    // ordering rule
    ////////////////////

    assign mul_idle = (mul_cnt == '0);
    assign mul_room = (mul_cnt != CW'(MUL_STAGES)) || mul_retire;

    always_comb begin
        case (cls)
            alu_op_pkg::cls_mul:
                req_ready = !single_valid && !div_busy && mul_enable && mul_room;
            alu_op_pkg::cls_div:
                req_ready = !single_valid && mul_idle && !div_busy && div_ready;
            default:
                req_ready = (!single_valid || single_ready) && mul_idle && !div_busy;
        endcase
    end

    assign single_load = req_valid && req_ready && (cls == alu_op_pkg::cls_single);
    assign mul_start   = req_valid && req_ready && (cls == alu_op_pkg::cls_mul);
    assign div_valid   = req_valid && (cls == alu_op_pkg::cls_div) && !single_valid
                         && mul_idle && !div_busy;   // no dependence on div_ready

    assign mul_a = op_a;
    assign mul_b = op_b;
    assign div_a = op_a;
    assign div_b = op_b;

    ////////////////////
    // single-cycle ops
    ////////////////////

    always_comb begin
        case (req.op)
            alu_op_pkg::op_not:        word = ~op_a;
            alu_op_pkg::op_and:        word = op_a & op_b;
            alu_op_pkg::op_or:         word = op_a | op_b;
            alu_op_pkg::op_xor:        word = op_a ^ op_b;
            alu_op_pkg::op_write_high: word = {op_b[15:0], op_a[15:0]};
            alu_op_pkg::op_write_low:  word = {op_a[31:16], op_b[15:0]};
            default:                   word = op_a;     // itof, ftoi
        endcase
        case (req.op)
            alu_op_pkg::op_add: wide = 64'(op_a) + 64'(op_b);  // 33-bit sum, extended
            alu_op_pkg::op_sub: wide = 64'(op_a) - 64'(op_b);
            default:            wide = 64'(word);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            single_valid <= 1'b0;
            mul_cnt      <= '0;
            div_busy     <= 1'b0;
        end else begin
            if (single_load) begin
                single_valid <= 1'b1;
            end else if (single_ready) begin
                single_valid <= 1'b0;
            end
            mul_cnt <= mul_cnt + CW'(mul_start) - CW'(mul_retire);
            if (div_valid && div_ready) begin
                div_busy <= 1'b1;
            end else if (div_retire) begin
                div_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (single_load) begin
            single_result.wide <= wide;
        end
    end

endmodule

// ==== mul/int_multiplier.sv ====
`timescale 1ns/10ps
// Pipelined signed multiplier

module int_multiplier #(
    parameter int MUL_STAGES = 3
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic                         start,
    input  logic signed [31:0]           a,
    input  logic signed [31:0]           b,
    output logic                         result_valid,
    output alu_result_pkg::unit_result_t result
);

    localparam int CHUNK = (32 + MUL_STAGES - 1) / MUL_STAGES;   // bits of b per stage

    logic signed [63:0]    acc [MUL_STAGES];   // running partial sums
    logic signed [31:0]    a_q [MUL_STAGES];
    logic [31:0]           b_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] vld;
    logic signed [63:0]    init;

    // a times one unsigned slice of b, placed at its weight
    function automatic logic signed [63:0] partial(input logic signed [31:0] x,
                                                   input logic [31:0] y, input int idx);
        logic [63:0] slice;
        slice   = ({32'd0, y} >> (idx * CHUNK)) & ((64'd1 << CHUNK) - 64'd1);
        partial = (64'(x) * $signed(slice)) <<< (idx * CHUNK);
    endfunction

    // b[31] weighs -2^31, the slices count it as +2^31
    assign init = b[31] ? -(64'(a) <<< 32) : 64'sd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else if (enable) begin
            vld <= MUL_STAGES'({vld, start});   // whole pipe moves together
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            acc[0] <= init + partial(a, b, 0);
            a_q[0] <= a;
            b_q[0] <= b;
            for (int i = 1; i < MUL_STAGES; i++) begin
                acc[i] <= acc[i-1] + partial(a_q[i-1], b_q[i-1], i);
                a_q[i] <= a_q[i-1];
                b_q[i] <= b_q[i-1];
            end
        end
    end

    assign result_valid = vld[MUL_STAGES-1];
    assign result.wide  = acc[MUL_STAGES-1];

endmodule

// ==== div/int_divider.sv ====
`timescale 1ns/10ps
// Iterative signed divider

module int_divider (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_valid,
    output logic                         start_ready,
    input  logic signed [31:0]           a,
    input  logic signed [31:0]           b,
    output logic                         done,
    input  logic                         taken,
    output alu_result_pkg::unit_result_t result
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix,
        st_hold
    } div_state_e;

    div_state_e         state;
    logic [4:0]         bit_cnt;
    logic [31:0]        rem;
    logic [31:0]        quo;            // dividend shifts out, quotient shifts in
    logic [31:0]        dvs;            // divisor magnitude
    logic               neg;
    logic [32:0]        shifted;
    logic [32:0]        diff;
    logic signed [31:0] q_signed;

    assign start_ready = (state == st_idle);
    assign done        = (state == st_hold);

    ////////////////////
    // one restoring step
    ////////////////////

    assign shifted = {1'b0, rem[30:0], quo[31]};
    assign diff    = shifted - {1'b0, dvs};

    // zero divisor gives all ones, -2^31 / -1 wraps by itself
    assign q_signed = (dvs == 32'd0) ? -32'sd1 : (neg ? -$signed(quo) : $signed(quo));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_valid) begin
                        state   <= st_run;
                        bit_cnt <= '0;
                    end
                end
                st_run: begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd31) begin
                        state <= st_fix;
                    end
                end
                st_fix:  state <= st_hold;
                default: begin
                    if (taken) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                rem <= 32'd0;
                quo <= a[31] ? 32'(-a) : a;     // load magnitudes
                dvs <= b[31] ? 32'(-b) : b;
                neg <= a[31] ^ b[31];
            end
            st_run: begin
                rem <= diff[32] ? shifted[31:0] : diff[31:0];
                quo <= {quo[30:0], ~diff[32]};
            end
            st_fix:  result.wide <= 64'(q_signed);
            default: ;
        endcase
    end

endmodule

// ==== src/result_merge.sv ====
`timescale 1ns/10ps
// Unit result merge

module result_merge (
    input  logic                         single_valid,
    output logic                         single_ready,
    input  alu_result_pkg::unit_result_t single_result,
    input  logic                         mul_valid,
    input  alu_result_pkg::unit_result_t mul_result,
    output logic                         mul_enable,
    input  logic                         div_done,
    input  alu_result_pkg::unit_result_t div_result,
    output logic                         div_taken,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output alu_result_pkg::alu_resp_t    rsp,
    output logic                         mul_retire,
    output logic                         div_retire
);

    logic signed [63:0] wide;

    // dispatch ordering leaves at most one source valid
    always_comb begin
        if (mul_valid) begin
            wide = mul_result.wide;
        end else if (div_done) begin
            wide = div_result.wide;
        end else begin
            wide = single_result.wide;
        end
    end

    assign rsp_valid = single_valid || mul_valid || div_done;

    assign rsp.data           = wide[31:0];
    assign rsp.flags.nonzero  = |wide;
    assign rsp.flags.negative = wide[63];

    ////////////////////
    // ready routing
    ////////////////////

    assign single_ready = rsp_ready && !mul_valid && !div_done;
    assign mul_enable   = !mul_valid || rsp_ready;     // freeze only with a stuck product
    assign div_taken    = div_done && rsp_ready;

    assign mul_retire = mul_valid && rsp_ready;
    assign div_retire = div_done && rsp_ready;

endmodule

// ==== src/int_alu.sv ====
`timescale 1ns/10ps
// Integer execution unit

module int_alu #(
    parameter int MUL_STAGES = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  alu_op_pkg::alu_req_t      in_req,
    output logic                      out_valid,
    input  logic                      out_ready,
    output alu_result_pkg::alu_resp_t out_resp
);

    logic                         req_valid;
    logic                         req_ready;
    alu_op_pkg::alu_req_t         req;
    logic                         single_valid;
    logic                         single_ready;
    alu_result_pkg::unit_result_t single_result;
    logic                         mul_start;
    logic                         mul_enable;
    logic signed [31:0]           mul_a;
    logic signed [31:0]           mul_b;
    logic                         mul_valid;
    alu_result_pkg::unit_result_t mul_result;
    logic                         div_valid;
    logic                         div_ready;
    logic signed [31:0]           div_a;
    logic signed [31:0]           div_b;
    logic                         div_done;
    logic                         div_taken;
    alu_result_pkg::unit_result_t div_result;
    logic                         mul_retire;
    logic                         div_retire;
    logic                         rsp_valid;
    logic                         rsp_ready;
    alu_result_pkg::alu_resp_t    rsp;

    ////////////////////
    // request side
    ////////////////////

    stream_skid #(.payload_t(alu_op_pkg::alu_req_t)) u_in_skid (
        .clk, .rst_n,
        .in_valid (in_valid),  .in_ready (in_ready),  .in_data  (in_req),
        .out_valid(req_valid), .out_ready(req_ready), .out_data (req)
    );

    alu_dispatch #(.MUL_STAGES(MUL_STAGES)) u_dispatch (
        .clk, .rst_n,
        .req_valid, .req_ready, .req,
        .single_valid, .single_ready, .single_result,
        .mul_start, .mul_enable, .mul_a, .mul_b,
        .div_valid, .div_ready, .div_a, .div_b,
        .mul_retire, .div_retire
    );

    ////////////////////
    // execution units
    ////////////////////

    int_multiplier #(.MUL_STAGES(MUL_STAGES)) u_mul (
        .clk, .rst_n,
        .enable      (mul_enable),
        .start       (mul_start),
        .a           (mul_a),
        .b           (mul_b),
        .result_valid(mul_valid),
        .result      (mul_result)
    );

    int_divider u_div (
        .clk, .rst_n,
        .start_valid(div_valid),
        .start_ready(div_ready),
        .a          (div_a),
        .b          (div_b),
        .done       (div_done),
        .taken      (div_taken),
        .result     (div_result)
    );

    ////////////////////
    // response side
    ////////////////////

    result_merge u_merge (
        .single_valid, .single_ready, .single_result,
        .mul_valid, .mul_result, .mul_enable,
        .div_done, .div_result, .div_taken,
        .rsp_valid, .rsp_ready, .rsp,
        .mul_retire, .div_retire
    );

    stream_skid #(.payload_t(alu_result_pkg::alu_resp_t)) u_out_skid (
        .clk, .rst_n,
        .in_valid (rsp_valid), .in_ready (rsp_ready), .in_data  (rsp),
        .out_valid(out_valid), .out_ready(out_ready), .out_data (out_resp)
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/10ps
// Testbench clock

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0);
        clk = ~clk;     // free running, both halves equal
    end

endmodule

// ==== dv/int_alu_assertions.sv ====
`timescale 1ns/10ps
// Execution unit stream checks

module int_alu_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      out_valid,
    input logic                      out_ready,
    input alu_result_pkg::alu_resp_t out_resp,
    input logic                      mul_valid,
    input logic                      div_done
);

    ////////////////////
    // output stream
    ////////////////////

    property p_out_hold;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_resp);
    endproperty

    a_out_hold: assert property (p_out_hold)
        else $error("stalled response was dropped or changed before its transfer");

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("output stream valid right after reset release");

    ////////////////////
    // unit exclusivity
    ////////////////////

    // ordering in dispatch leaves one unit with a result at a time
    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n) !(mul_valid && div_done))
        else $error("multiplier and divider offer results in the same cycle");

endmodule

// ==== dv/int_alu_tb.sv ====
`timescale 1ns/10ps
// Execution unit testbench

module int_alu_tb;

    localparam int MUL_STAGES     = 3;
    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 * 3;  // 40 cycles each, x3 for back-pressure
    localparam int DRIVE_DELAY    = 1;
    localparam int BURST_LEN      = 16;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic                      in_ready;
    alu_op_pkg::alu_req_t      in_req;
    logic                      out_valid;
    logic                      out_ready;
    alu_result_pkg::alu_resp_t out_resp;

    integer                    seed = 7546;
    alu_result_pkg::alu_resp_t expected [$];    // model results in request order
    alu_result_pkg::alu_resp_t exp_resp;
    int                        cycle_cnt = 0;
    int                        n_sent    = 0;
    int                        n_checked = 0;
    int                        stall_cnt = 0;   // cycles with in_valid high and in_ready low
    int                        bp_pct    = 0;   // chance of out_ready low, in percent

    tb_clock #(.PERIOD_NS(8.0)) u_clock (.clk(clk));

    int_alu #(.MUL_STAGES(MUL_STAGES)) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_resp (out_resp)
    );

    bind int_alu int_alu_assertions u_assertions (
        .clk      (clk),
        .rst_n    (rst_n),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_resp (out_resp),
        .mul_valid(mul_valid),
        .div_done (div_done)
    );

    ////////////////////
    // reporting
    ////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            fail_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, exp_v, act_v));
        end
    endtask

    task automatic check_flags(input string name, input alu_result_pkg::alu_flags_t exp_v,
                               input alu_result_pkg::alu_flags_t act_v);
        if (act_v !== exp_v) begin
            fail_run($sformatf("Error at %0t: %s expected %b, actual %b",
                               $time, name, exp_v, act_v));
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic alu_result_pkg::alu_resp_t model_resp(input alu_op_pkg::alu_req_t r);
        alu_result_pkg::alu_resp_t res;
        longint                    sa;
        longint                    sb;
        longint                    full;    // value at its natural precision
        logic [31:0]               w;
        sa = longint'($signed(r.a));
        sb = longint'($signed(r.b));
        w  = r.a;                           // itof and ftoi pass a
        case (r.op)
            alu_op_pkg::op_not:        w = ~r.a;
            alu_op_pkg::op_and:        w = r.a & r.b;
            alu_op_pkg::op_or:         w = r.a | r.b;
            alu_op_pkg::op_xor:        w = r.a ^ r.b;
            alu_op_pkg::op_write_high: w = {r.b[15:0], r.a[15:0]};
            alu_op_pkg::op_write_low:  w = {r.a[31:16], r.b[15:0]};
            alu_op_pkg::op_div: begin
                if (sb == 0) begin
                    w = 32'hffff_ffff;
                end else begin
                    full = sa / sb;         // truncates toward zero
                    w    = full[31:0];      // -2^31 / -1 wraps here
                end
            end
            default: ;
        endcase
        case (r.op)
            alu_op_pkg::op_add: full = sa + sb;
            alu_op_pkg::op_sub: full = sa - sb;
            alu_op_pkg::op_mul: full = sa * sb;
            default:            full = longint'($signed(w));
        endcase
        res.data           = full[31:0];
        res.flags.nonzero  = (full != 0);
        res.flags.negative = (full < 0);
        return res;
    endfunction

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic draw_below(input int range, output int v);
        v = $unsigned($random(seed)) % range;
    endtask

    task automatic next_cycle();
        int pick;
        @(posedge clk);
        #(DRIVE_DELAY);
        draw_below(100, pick);
        out_ready = (pick >= bp_pct);
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic rand_word(output logic signed [31:0] v);
        int pick;
        draw_below(8, pick);
        case (pick)
            0:       v = 32'sd0;
            1:       v = -32'sd1;
            2:       v = 32'sh8000_0000;
            3:       v = 32'sh7fff_ffff;
            4:       v = $random(seed) % 16;    // small, either sign
            default: v = $random(seed);
        endcase
    endtask

    task automatic random_single(input logic with_special, output alu_op_pkg::alu_op_e op);
        int pick;
        draw_below(with_special ? 10 : 6, pick);
        case (pick)
            0:       op = alu_op_pkg::op_add;
            1:       op = alu_op_pkg::op_sub;
            2:       op = alu_op_pkg::op_not;
            3:       op = alu_op_pkg::op_and;
            4:       op = alu_op_pkg::op_or;
            5:       op = alu_op_pkg::op_xor;
            6:       op = alu_op_pkg::op_write_high;
            7:       op = alu_op_pkg::op_write_low;
            8:       op = alu_op_pkg::op_itof;
            default: op = alu_op_pkg::op_ftoi;
        endcase
    endtask

    // holds valid until the transfer, returns one step past the accepting edge
    task automatic send_req(input alu_op_pkg::alu_req_t r);
        logic ready_seen;
        in_req     = r;
        in_valid   = 1'b1;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            ready_seen = in_ready;
            if (!ready_seen) begin
                stall_cnt++;
            end
            next_cycle();
        end
        n_sent++;
    endtask

    task automatic send_op(input alu_op_pkg::alu_op_e op, input logic signed [31:0] a,
                           input logic signed [31:0] b);
        alu_op_pkg::alu_req_t r;
        r.op = op;
        r.a  = a;
        r.b  = b;
        send_req(r);
    endtask

    task automatic wait_drain();
        in_valid = 1'b0;
        while (expected.size() != 0) begin
            next_cycle();
        end
    endtask

    ////////////////////
    // monitor and timeout
    ////////////////////

    // sampled mid-cycle, the handshake at the next edge is already decided
    always @(negedge clk) begin
        if (rst_n && in_valid && in_ready) begin
            expected.push_back(model_resp(in_req));
        end
        if (rst_n && out_valid && out_ready) begin
            if (expected.size() == 0) begin
                fail_run("a result came out while no request was outstanding");
            end else begin
                exp_resp = expected.pop_front();
                check_data("out_resp.data", exp_resp.data, out_resp.data);
                check_flags("out_resp.flags", exp_resp.flags, out_resp.flags);
                n_checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, the ALU stopped making progress",
                               cycle_cnt));
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        logic signed [31:0]  a_v;
        logic signed [31:0]  b_v;
        alu_op_pkg::alu_op_e op_v;
        int                  kind;
        int                  len;
        int                  gap;

        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n     = 1'b1;
        out_ready = 1'b1;

        // add, sub and logic with 33-bit flag cases
        send_op(alu_op_pkg::op_add, 32'sh7fff_ffff, 32'sd1);
        send_op(alu_op_pkg::op_add, -32'sd1, 32'sd1);
        send_op(alu_op_pkg::op_add, 32'sh8000_0000, 32'sh8000_0000);
        send_op(alu_op_pkg::op_sub, 32'sd0, 32'sd1);
        send_op(alu_op_pkg::op_sub, 32'sh8000_0000, 32'sd1);
        send_op(alu_op_pkg::op_not, -32'sd1, 32'sd0);
        send_op(alu_op_pkg::op_and, 32'shffff_0000, 32'sh0f0f_0f0f);
        send_op(alu_op_pkg::op_xor, 32'sh5a5a_5a5a, 32'sh5a5a_5a5a);
        for (int i = 0; i < 52; i++) begin
            random_single(1'b0, op_v);
            rand_word(a_v);
            rand_word(b_v);
            send_op(op_v, a_v, b_v);
        end

        // half-word merges and pass-through
        send_op(alu_op_pkg::op_write_high, 32'sh1234_5678, 32'shabcd_ef01);
        send_op(alu_op_pkg::op_write_low, 32'sh1234_5678, 32'shabcd_ef01);
        send_op(alu_op_pkg::op_itof, 32'sh8000_0000, 32'sd5);
        send_op(alu_op_pkg::op_ftoi, 32'sd0, -32'sd1);
        for (int i = 0; i < 26; i++) begin
            draw_below(4, kind);
            op_v = alu_op_pkg::alu_op_e'(4'(8 + kind));
            rand_word(a_v);
            rand_word(b_v);
            send_op(op_v, a_v, b_v);
            draw_below(3, gap);
            idle_cycles(gap);
        end

        // back-to-back multiplies, one accepted per cycle
        for (int burst = 0; burst < 4; burst++) begin
            wait_drain();
            stall_cnt = 0;
            for (int i = 0; i < BURST_LEN; i++) begin
                if (burst == 0 && i == 0) begin
                    a_v = 32'sh8000_0000;
                    b_v = 32'sh8000_0000;
                end else begin
                    rand_word(a_v);
                    rand_word(b_v);
                end
                send_op(alu_op_pkg::op_mul, a_v, b_v);
            end
            in_valid = 1'b0;
            if (stall_cnt != 0) begin
                fail_run($sformatf("multiply burst stalled the input for %0d cycles", stall_cnt));
            end
        end

        // divides with mixed signs and the special cases
        wait_drain();
        send_op(alu_op_pkg::op_div, 32'sd7, 32'sd2);
        send_op(alu_op_pkg::op_div, -32'sd7, 32'sd2);
        send_op(alu_op_pkg::op_div, 32'sd7, -32'sd2);
        send_op(alu_op_pkg::op_div, -32'sd7, -32'sd2);
        send_op(alu_op_pkg::op_div, 32'sd1234, 32'sd0);
        send_op(alu_op_pkg::op_div, 32'sd0, 32'sd0);
        send_op(alu_op_pkg::op_div, 32'sh8000_0000, -32'sd1);
        send_op(alu_op_pkg::op_div, 32'sh8000_0000, 32'sd1);
        send_op(alu_op_pkg::op_div, 32'sd5, 32'sd7);
        send_op(alu_op_pkg::op_div, -32'sd5, 32'sd7);
        for (int i = 0; i < 30; i++) begin
            rand_word(a_v);
            rand_word(b_v);
            send_op(alu_op_pkg::op_div, a_v, b_v);
        end

        // mixed classes in bursts under output back-pressure
        wait_drain();
        bp_pct = 40;
        while (n_sent < NUM_REQ) begin
            draw_below(100, kind);
            draw_below(6, len);
            for (int i = 0; i <= len && n_sent < NUM_REQ; i++) begin
                if (kind < 35) begin
                    op_v = alu_op_pkg::op_mul;
                end else if (kind < 55) begin
                    op_v = alu_op_pkg::op_div;
                end else begin
                    random_single(1'b1, op_v);
                end
                rand_word(a_v);
                rand_word(b_v);
                send_op(op_v, a_v, b_v);
            end
            draw_below(4, gap);
            idle_cycles((gap == 0) ? 2 : 0);
        end

        wait_drain();
        bp_pct = 0;
        idle_cycles(20);    // any extra result would show up here
        if (expected.size() == 0 && n_checked == NUM_REQ) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run($sformatf("run ended with %0d of %0d results checked",
                               n_checked, NUM_REQ));
        end
    end

endmodule

// ==== tb.f ====
common/alu_op_pkg.sv
common/alu_result_pkg.sv
src/stream_skid.sv
src/alu_dispatch.sv
mul/int_multiplier.sv
div/int_divider.sv
src/result_merge.sv
src/int_alu.sv
dv/tb_clock.sv
dv/int_alu_assertions.sv
dv/int_alu_tb.sv
